//--- hdl/cpuPkg.sv
package cpuPkg;

    // Data words and word addresses
    typedef logic [31:0] word_t;

    // Register number, sixteen registers
    typedef logic [3:0] regAddr_t;

    // Opcode field, instruction bits 31 to 27
    typedef enum logic [4:0] {
        opLoad    = 5'd0,
        opLoadImm = 5'd1,
        opStore   = 5'd2,
        opAdd     = 5'd3,
        opSub     = 5'd4,
        opAnd     = 5'd5,
        opOr      = 5'd6,
        opRor     = 5'd7,
        opRol     = 5'd8,
        opSrl     = 5'd9,
        opSra     = 5'd10,
        opSll     = 5'd11,
        opAddImm  = 5'd12,
        opAndImm  = 5'd13,
        opOrImm   = 5'd14,
        opNeg     = 5'd15,
        opNot     = 5'd16,
        opBranch  = 5'd17,
        opJal     = 5'd18,
        opJfr     = 5'd19,
        opNop     = 5'd20,
        opHalt    = 5'd21
    } opCode_t;

    // ALU functions
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluRor, aluRol,
        aluSrl, aluSra, aluSll, aluNeg, aluNot, aluPassB
    } aluOp_t;

    // One-hot instruction steps
    typedef enum logic [4:0] {
        stepFetch     = 5'b00001,
        stepRegRead   = 5'b00010,
        stepExecute   = 5'b00100,
        stepMemAccess = 5'b01000,
        stepWriteBack = 5'b10000
    } step_t;

    // Branch condition, instruction bits 20 to 19
    typedef enum logic [1:0] {
        condZero, condNonZero, condPositive, condNegative
    } brCond_t;

    // Control bundle into the datapath
    typedef struct packed {
        logic     pcInc;
        logic     pcLoad;
        logic     irLoad;
        logic     aLoad;
        logic     bLoad;
        logic     zLoad;
        logic     marLoad;
        logic     rfWrite;
        logic     bSelImm;
        logic     marSelPc;
        logic     pcSelReg;
        logic     wbSelMem;
        aluOp_t   aluOp;
        regAddr_t rdA;
        regAddr_t rdB;
        regAddr_t wrC;
    } ctrl_t;

endpackage

//--- hdl/instrDecode.sv
`timescale 1ns/1ns

module instrDecode import cpuPkg::*; (
    input  word_t    instr,
    output opCode_t  opCode,
    output regAddr_t ra,
    output regAddr_t rb,
    output regAddr_t rc,
    output word_t    imm,
    output logic     isRegFmt,
    output logic     isImmFmt
);

    logic [4:0] rawOp;

    assign rawOp = instr[31:27];

    // Codes past halt run as a no-op
    assign opCode = (rawOp <= 5'd21) ? opCode_t'(rawOp) : opNop;

    // Register fields
    assign ra = instr[26:23];
    assign rb = instr[22:19];
    assign rc = instr[18:15];

    // 19-bit immediate, sign-extended
    assign imm = {{13{instr[18]}}, instr[18:0]};

    // Format flags for the control muxes
    always_comb begin
        isRegFmt = 1'b0;
        isImmFmt = 1'b0;
        case (opCode)
            opAdd, opSub, opAnd, opOr, opRor,
            opRol, opSrl, opSra, opSll: begin
                isRegFmt = 1'b1;
            end
            opLoad, opLoadImm, opStore, opAddImm,
            opAndImm, opOrImm, opNeg, opNot: begin
                isImmFmt = 1'b1;
            end
            // Branch, jumps, nop and halt
            default: begin
                isRegFmt = 1'b0;
                isImmFmt = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ns

module regFile import cpuPkg::*; (
    input  logic     iClk,
    input  logic     nRst,
    input  logic     iRdy,
    input  regAddr_t rdA,
    input  regAddr_t rdB,
    input  regAddr_t wrC,
    input  logic     wrEn,
    input  word_t    wrData,
    output word_t    rdDataA,
    output word_t    rdDataB
);

    word_t regs [16];

    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && iRdy) begin
            regs[wrC] <= wrData;
        end
    end

    // Register 0 is hardwired to zero on both read ports
    assign rdDataA = (rdA == '0) ? '0 : regs[rdA];
    assign rdDataB = (rdB == '0) ? '0 : regs[rdB];

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ns

module alu import cpuPkg::*; (
    input  word_t   aIn,
    input  word_t   bIn,
    input  aluOp_t  op,
    input  brCond_t cond,
    input  word_t   condVal,
    output word_t   result,
    output logic    brTaken
);

    logic [4:0]  shAmt;
    logic [63:0] dblRight;
    logic [63:0] dblLeft;

    assign shAmt = bIn[4:0];

    // Rotates via a doubled word
    assign dblRight = {aIn, aIn} >> shAmt;
    assign dblLeft  = {aIn, aIn} << shAmt;

    always_comb begin
        case (op)
            aluAdd:   result = aIn + bIn;
            aluSub:   result = aIn - bIn;
            aluAnd:   result = aIn & bIn;
            aluOr:    result = aIn | bIn;
            aluRor:   result = dblRight[31:0];
            aluRol:   result = dblLeft[63:32];
            aluSrl:   result = aIn >> shAmt;
            aluSra:   result = word_t'($signed(aIn) >>> shAmt);
            aluSll:   result = aIn << shAmt;
            aluNeg:   result = '0 - aIn;
            aluNot:   result = ~aIn;
            default:  result = bIn;
        endcase
    end

    // Branch test on the ra value, signed compares
    always_comb begin
        case (cond)
            condZero:     brTaken = (condVal == '0);
            condNonZero:  brTaken = (condVal != '0);
            condPositive: brTaken = ($signed(condVal) > 0);
            default:      brTaken = ($signed(condVal) < 0);
        endcase
    end

endmodule

//--- hdl/cpuControl.sv
`timescale 1ns/1ns

module cpuControl import cpuPkg::*; (
    input  logic  iClk,
    input  logic  nRst,
    input  logic  iRdy,
    input  word_t iMemData,
    input  logic  brTaken,
    output ctrl_t ctrl,
    output logic  memRead,
    output logic  memWrite,
    output logic  halted
);

    step_t    step;
    word_t    instrReg;
    opCode_t  opCode;
    regAddr_t ra;
    regAddr_t rb;
    regAddr_t rc;
    word_t    imm;
    logic     isRegFmt;
    logic     isImmFmt;

    // Step ring, frozen by low ready and after halt
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            step <= stepFetch;
        end else if (iRdy && !halted) begin
            step <= step_t'({step[3:0], step[4]});
        end
    end

    // Instruction register, filled during fetch
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            instrReg <= '0;
        end else if (iRdy && ctrl.irLoad) begin
            instrReg <= iMemData;
        end
    end

    // Halt takes effect at the end of its execute step
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            halted <= 1'b0;
        end else if (iRdy && step == stepExecute && opCode == opHalt) begin
            halted <= 1'b1;
        end
    end

    instrDecode u_instrDecode (
        .instr    (instrReg),
        .opCode   (opCode),
        .ra       (ra),
        .rb       (rb),
        .rc       (rc),
        .imm      (imm),
        .isRegFmt (isRegFmt),
        .isImmFmt (isImmFmt)
    );

    always_comb begin
        // Step enables
        ctrl.pcInc   = (step == stepFetch);
        ctrl.irLoad  = (step == stepFetch);
        ctrl.aLoad   = (step == stepRegRead);
        ctrl.bLoad   = (step == stepRegRead);
        ctrl.zLoad   = (step == stepExecute);
        // Jumps always, branch only when its test passes
        ctrl.pcLoad  = (step == stepExecute) &&
                       (opCode == opJal || opCode == opJfr || (opCode == opBranch && brTaken));
        ctrl.pcSelReg = (opCode == opJal || opCode == opJfr);
        // MAR takes the ALU sum for load/store, then the PC for the next fetch
        ctrl.marSelPc = (step == stepWriteBack);
        ctrl.marLoad  = (step == stepWriteBack) ||
                        (step == stepExecute && (opCode == opLoad || opCode == opStore));
        // Immediate feeds ALU B for every I-format op
        ctrl.bSelImm  = isImmFmt;
        // Held over memory access and write-back of a load
        ctrl.wbSelMem = (opCode == opLoad) &&
                        (step == stepMemAccess || step == stepWriteBack);
        ctrl.rfWrite  = (step == stepWriteBack) &&
                        (isRegFmt || (isImmFmt && opCode != opStore) || opCode == opJal);
        // Register numbers, rb slot also carries the branch condition
        ctrl.rdA = (opCode == opJfr) ? ra : rb;
        ctrl.rdB = (opCode == opStore || opCode == opBranch) ? ra : rc;
        ctrl.wrC = ra;
    end

    // ALU function per opcode
    always_comb begin
        case (opCode)
            opLoad, opLoadImm, opStore,
            opAdd, opAddImm:  ctrl.aluOp = aluAdd;
            opSub:            ctrl.aluOp = aluSub;
            opAnd, opAndImm:  ctrl.aluOp = aluAnd;
            opOr, opOrImm:    ctrl.aluOp = aluOr;
            opRor:            ctrl.aluOp = aluRor;
            opRol:            ctrl.aluOp = aluRol;
            opSrl:            ctrl.aluOp = aluSrl;
            opSra:            ctrl.aluOp = aluSra;
            opSll:            ctrl.aluOp = aluSll;
            opNeg:            ctrl.aluOp = aluNeg;
            opNot:            ctrl.aluOp = aluNot;
            default:          ctrl.aluOp = aluPassB;
        endcase
    end

    // Memory strobes
    assign memRead  = !halted &&
                      (step == stepFetch || (step == stepMemAccess && opCode == opLoad));
    assign memWrite = (step == stepMemAccess) && (opCode == opStore);

endmodule

//--- hdl/dataPath.sv
`timescale 1ns/1ns

module dataPath import cpuPkg::*; #(
    parameter word_t resetPc = '0
) (
    input  logic  iClk,
    input  logic  nRst,
    input  logic  iRdy,
    input  ctrl_t ctrl,
    input  word_t imm,
    input  word_t iMemData,
    output logic  brTaken,
    output word_t memAddr,
    output word_t memWData
);

    word_t pc;
    word_t regA;
    word_t regB;
    word_t regZ;
    word_t mar;
    word_t mdr;
    word_t rfDataA;
    word_t rfDataB;
    word_t aluB;
    word_t aluResult;
    word_t wbData;
    word_t pcNext;
    logic  mdrFromMem;
    logic  mdrFromB;

    // Register or immediate into ALU B
    assign aluB = ctrl.bSelImm ? imm : regB;

    // Jump to register A, or relative branch off the incremented PC
    assign pcNext = ctrl.pcSelReg ? regA : pc + imm;

    // Write-back source
    assign wbData = ctrl.wbSelMem ? mdr : regZ;

    // MDR captures read data in a load's memory step
    assign mdrFromMem = ctrl.wbSelMem && !ctrl.rfWrite;
    // Store data comes from B when the address is computed
    assign mdrFromB = ctrl.marLoad && !ctrl.marSelPc;

    regFile u_regFile (
        .iClk    (iClk),
        .nRst    (nRst),
        .iRdy    (iRdy),
        .rdA     (ctrl.rdA),
        .rdB     (ctrl.rdB),
        .wrC     (ctrl.wrC),
        .wrEn    (ctrl.rfWrite),
        .wrData  (wbData),
        .rdDataA (rfDataA),
        .rdDataB (rfDataB)
    );

    // Condition code sits in the low bits of the rb slot
    alu u_alu (
        .aIn     (regA),
        .bIn     (aluB),
        .op      (ctrl.aluOp),
        .cond    (brCond_t'(ctrl.rdA[1:0])),
        .condVal (regB),
        .result  (aluResult),
        .brTaken (brTaken)
    );

    // PC and MAR both start at the reset vector
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            pc  <= resetPc;
            mar <= resetPc;
        end else if (iRdy) begin
            if (ctrl.pcLoad) begin
                pc <= pcNext;
            end else if (ctrl.pcInc) begin
                pc <= pc + 32'd1;
            end
            if (ctrl.marLoad) begin
                mar <= ctrl.marSelPc ? pc : aluResult;
            end
        end
    end

    // Operand, result and data registers
    always_ff @(posedge iClk) begin
        if (iRdy) begin
            if (ctrl.aLoad) begin
                regA <= rfDataA;
            end
            if (ctrl.bLoad) begin
                regB <= rfDataB;
            end
            // Jal links the old PC through Z
            if (ctrl.zLoad) begin
                regZ <= ctrl.pcSelReg ? pc : aluResult;
            end
            if (mdrFromMem) begin
                mdr <= iMemData;
            end else if (mdrFromB) begin
                mdr <= regB;
            end
        end
    end

    assign memAddr  = mar;
    assign memWData = mdr;

endmodule

//--- hdl/miniCpu.sv
`timescale 1ns/1ns

module miniCpu import cpuPkg::*; #(
    parameter word_t resetPc = '0
) (
    input  logic  iClk,
    input  logic  nRst,
    input  logic  iRdy,
    input  word_t iMemData,
    output word_t memAddr,
    output word_t memWData,
    output logic  memRead,
    output logic  memWrite,
    output logic  halted
);

    ctrl_t ctrl;
    logic  brTaken;
    word_t imm;

    // Step sequencing, decode and memory strobes
    cpuControl u_cpuControl (
        .iClk     (iClk),
        .nRst     (nRst),
        .iRdy     (iRdy),
        .iMemData (iMemData),
        .brTaken  (brTaken),
        .ctrl     (ctrl),
        .memRead  (memRead),
        .memWrite (memWrite),
        .halted   (halted)
    );

    // Sign-extended immediate from the decoder
    assign imm = u_cpuControl.imm;

    // Registers, ALU and memory interface
    dataPath #(
        .resetPc (resetPc)
    ) u_dataPath (
        .iClk     (iClk),
        .nRst     (nRst),
        .iRdy     (iRdy),
        .ctrl     (ctrl),
        .imm      (imm),
        .iMemData (iMemData),
        .brTaken  (brTaken),
        .memAddr  (memAddr),
        .memWData (memWData)
    );

endmodule

//--- testbench/tbMemory.sv
`timescale 1ns/1ns

module tbMemory import cpuPkg::*; (
    input  logic  iClk,
    input  word_t addr,
    input  word_t wData,
    input  logic  write,
    output word_t rdData,
    output logic  rdy
);

    // 256 words, upper address bits ignored
    word_t  mem [256];
    integer seed = 32'ha264_df3c;

    // Fill pattern built from every bit of the word index
    initial begin
        rdy = 1'b0;
        for (int a = 0; a < 256; a++) begin
            mem[a] <= {8'hA5, 8'(a), ~8'(a), 8'(a) ^ 8'h3C};
        end
    end

    // Read data follows the address with no clock
    assign rdData = mem[addr[7:0]];

    // Write only on an edge the core accepts
    always @(posedge iClk) begin
        if (write && rdy) begin
            mem[addr[7:0]] <= wData;
        end
    end

    // Ready level moves 2 ns after each rising edge
    // high three cycles in four on average
    always begin
        @(posedge iClk);
        #2;
        rdy = (($random(seed) & 3) != 0);
    end

endmodule

//--- testbench/miniCpuTb.sv
`timescale 1ns/1ns

module miniCpuTb import cpuPkg::*; ();

    localparam word_t resetPc = 32'h0;
    // Stored results live above the code
    localparam int dataBase = 'hC0;

    logic  iClk;
    logic  nRst;
    logic  iRdy;
    word_t iMemData;
    word_t memAddr;
    word_t memWData;
    logic  memRead;
    logic  memWrite;
    logic  halted;

    // Program image and the reference model's expected traffic
    word_t  prog[$];
    word_t  fetchQ[$];
    word_t  storeAddrQ[$];
    word_t  storeDataQ[$];
    word_t  loadAddrQ[$];
    word_t  modelMem[256];
    word_t  modelRegs[16];
    integer seed = 32'ha264_df3c;
    int     instrCount = 0;
    int     mismatchCount = 0;
    int     failCount = 0;
    // Monitor state
    int     phase = 0;
    int     fetchIdx = 0;
    int     storeIdx = 0;
    int     loadIdx = 0;
    bit     modelReady = 1'b0;
    bit     haltSeen = 1'b0;
    bit     sampled = 1'b0;
    logic   prevRdy;
    logic   prevRead;
    logic   prevWrite;
    word_t  prevAddr;

    miniCpu #(
        .resetPc (resetPc)
    ) i_miniCpu (
        .iClk     (iClk),
        .nRst     (nRst),
        .iRdy     (iRdy),
        .iMemData (iMemData),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memRead  (memRead),
        .memWrite (memWrite),
        .halted   (halted)
    );

    tbMemory u_tbMemory (
        .iClk   (iClk),
        .addr   (memAddr),
        .wData  (memWData),
        .write  (memWrite),
        .rdData (iMemData),
        .rdy    (iRdy)
    );

    initial begin
        iClk = 1'b0;
        forever #10 iClk = ~iClk;
    end

    task automatic mismatch(string name, word_t expVal, word_t actVal);
        $display("MISMATCH %s expected %h actual %h at %0t", name, expVal, actVal, $time);
        mismatchCount++;
    endtask

    task automatic failure(string what);
        $display("ERROR: %s at %0t", what, $time);
        failCount++;
    endtask

    task automatic finishRun();
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // Instruction encoders with opcode 31:27 ra 26:23 rb 22:19 rc 18:15 imm 18:0
    function automatic word_t encR(opCode_t op, regAddr_t ra, regAddr_t rb, regAddr_t rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic word_t encI(opCode_t op, regAddr_t ra, regAddr_t rb, logic [18:0] imm);
        return {op, ra, rb, imm};
    endfunction

    task automatic emit(word_t w);
        prog.push_back(w);
    endtask

    // Taken branch jumps over the counter bump
    task automatic branchSkip(regAddr_t r, brCond_t c);
        emit(encI(opBranch, r, regAddr_t'(c), 19'd1));
        emit(encI(opAddImm, 4'd14, 4'd14, 19'd1));
    endtask

    task automatic buildProgram();
        opCode_t  aluOps[14] = '{opAdd, opSub, opAnd, opOr, opRor, opRol, opSrl, opSra,
                                 opSll, opAddImm, opAndImm, opOrImm, opNeg, opNot};
        opCode_t  op;
        regAddr_t ra;
        regAddr_t rb;
        regAddr_t rc;
        int       dataPtr;
        int       subFix;
        dataPtr = dataBase;
        // Random starting values in r1..r7
        for (int r = 1; r < 8; r++) begin
            emit(encI(opLoadImm, regAddr_t'(r), 4'd0, 19'($random(seed))));
        end
        // Each ALU function twice on random registers with every result stored
        for (int k = 0; k < 28; k++) begin
            op = aluOps[k % 14];
            ra = regAddr_t'(1 + $unsigned($random(seed)) % 7);
            rb = regAddr_t'($unsigned($random(seed)) % 8);
            rc = regAddr_t'($unsigned($random(seed)) % 8);
            if (k % 14 < 9) begin
                emit(encR(op, ra, rb, rc));
            end else begin
                emit(encI(op, ra, rb, 19'($random(seed))));
            end
            emit(encI(opStore, ra, 4'd0, 19'(dataPtr)));
            dataPtr++;
        end
        // r0 ignores writes and reads zero
        emit(encI(opAddImm, 4'd0, 4'd1, 19'd5));
        emit(encI(opStore, 4'd0, 4'd0, 19'(dataPtr)));
        emit(encR(opOr, 4'd1, 4'd0, 4'd0));
        emit(encI(opStore, 4'd1, 4'd0, 19'(dataPtr + 1)));
        dataPtr += 2;
        // Load back early results and store them again
        for (int j = 0; j < 4; j++) begin
            emit(encI(opLoad, 4'd8, 4'd0, 19'(dataBase + j)));
            emit(encI(opStore, 4'd8, 4'd0, 19'(dataPtr)));
            dataPtr++;
        end
        // Base register with a negative offset
        emit(encI(opLoadImm, 4'd9, 4'd0, 19'(dataBase + 4)));
        emit(encI(opLoad, 4'd10, 4'd9, 19'(-2)));
        emit(encI(opStore, 4'd10, 4'd9, 19'(dataPtr - dataBase - 4)));
        dataPtr++;
        // Branch operands zero, positive and negative
        // r14 counts fall-throughs
        emit(encI(opLoadImm, 4'd11, 4'd0, 19'd0));
        emit(encI(opLoadImm, 4'd12, 4'd0, 19'd5));
        emit(encI(opLoadImm, 4'd13, 4'd0, 19'(-3)));
        emit(encI(opLoadImm, 4'd14, 4'd0, 19'd0));
        branchSkip(4'd11, condZero);
        branchSkip(4'd12, condZero);
        branchSkip(4'd12, condNonZero);
        branchSkip(4'd11, condNonZero);
        branchSkip(4'd12, condPositive);
        branchSkip(4'd11, condPositive);
        branchSkip(4'd13, condPositive);
        branchSkip(4'd13, condNegative);
        branchSkip(4'd11, condNegative);
        // Backward loop of three passes
        emit(encI(opLoadImm, 4'd15, 4'd0, 19'd3));
        emit(encI(opAddImm, 4'd15, 4'd15, 19'(-1)));
        emit(encI(opBranch, 4'd15, regAddr_t'(condNonZero), 19'(-2)));
        emit(encR(opNop, 4'd0, 4'd0, 4'd0));
        // Undefined opcode
        emit({5'd27, 27'h123_4567});
        // Call through r9 with the link in r10
        subFix = prog.size();
        emit('0);
        emit(encR(opJal, 4'd10, 4'd9, 4'd0));
        emit(encI(opStore, 4'd10, 4'd0, 19'(dataPtr)));
        emit(encI(opStore, 4'd14, 4'd0, 19'(dataPtr + 1)));
        emit(encR(opHalt, 4'd0, 4'd0, 4'd0));
        prog[subFix] = encI(opLoadImm, 4'd9, 4'd0, 19'(prog.size()));
        // Subroutine
        emit(encI(opAddImm, 4'd14, 4'd14, 19'd16));
        emit(encR(opJfr, 4'd10, 4'd0, 4'd0));
    endtask

    function automatic word_t regVal(regAddr_t r);
        return (r == 4'd0) ? 32'd0 : modelRegs[r];
    endfunction

    function automatic word_t rotRight(word_t x, logic [4:0] n);
        return (n == 5'd0) ? x : ((x >> n) | (x << (6'd32 - n)));
    endfunction

    // Instruction-level model that ignores ready timing
    task automatic runModel();
        word_t      ir;
        word_t      pc;
        word_t      nextPc;
        word_t      va;
        word_t      vc;
        word_t      vr;
        word_t      imm;
        word_t      res;
        logic [4:0] op;
        regAddr_t   ra;
        bit         wr;
        bit         taken;
        bit         done;
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = '0;
        end
        foreach (prog[i]) begin
            modelMem[i] = prog[i];
        end
        pc = resetPc;
        done = 1'b0;
        while (!done && instrCount < 2000) begin
            ir = modelMem[pc[7:0]];
            fetchQ.push_back(pc);
            instrCount++;
            op = ir[31:27];
            ra = ir[26:23];
            va = regVal(ir[22:19]);
            vc = regVal(ir[18:15]);
            vr = regVal(ra);
            imm = 32'($signed(ir[18:0]));
            nextPc = pc + 1;
            wr = 1'b1;
            res = '0;
            case (op)
                5'd0: begin
                    loadAddrQ.push_back(va + imm);
                    res = modelMem[8'(va + imm)];
                end
                5'd1: res = va + imm;
                5'd2: begin
                    storeAddrQ.push_back(va + imm);
                    storeDataQ.push_back(vr);
                    modelMem[8'(va + imm)] = vr;
                    wr = 1'b0;
                end
                5'd3: res = va + vc;
                5'd4: res = va - vc;
                5'd5: res = va & vc;
                5'd6: res = va | vc;
                5'd7: res = rotRight(va, vc[4:0]);
                // Left rotate by n is a right rotate by 32 - n
                5'd8: res = rotRight(va, 5'd0 - vc[4:0]);
                5'd9: res = va >> vc[4:0];
                // Logical shift, then copies of the sign bit into the vacated top bits
                5'd10: begin
                    res = va >> vc[4:0];
                    if (va[31]) begin
                        res = res | ~(32'hFFFF_FFFF >> vc[4:0]);
                    end
                end
                5'd11: res = va << vc[4:0];
                5'd12: res = va + imm;
                5'd13: res = va & imm;
                5'd14: res = va | imm;
                5'd15: res = ~va + 1;
                5'd16: res = ~va;
                5'd17: begin
                    case (ir[20:19])
                        2'd0: taken = (vr == 0);
                        2'd1: taken = (vr != 0);
                        2'd2: taken = !vr[31] && (vr != 0);
                        default: taken = vr[31];
                    endcase
                    if (taken) begin
                        nextPc = pc + 1 + imm;
                    end
                    wr = 1'b0;
                end
                // Link is the address after the jump
                5'd18: begin
                    res = pc + 1;
                    nextPc = va;
                end
                5'd19: begin
                    nextPc = vr;
                    wr = 1'b0;
                end
                5'd21: begin
                    done = 1'b1;
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && ra != 4'd0) begin
                modelRegs[ra] = res;
            end
            pc = nextPc;
        end
        assert (done) else failure("reference model never reached halt");
    endtask

    // Checks for one accepted step
    task automatic checkStep();
        if (phase == 0) begin
            assert (memRead) else failure("memory read missing in fetch step");
            assert (fetchIdx < fetchQ.size()) else failure("fetch past the end of the program");
            if (fetchIdx < fetchQ.size()) begin
                assert (memAddr == fetchQ[fetchIdx])
                    else mismatch("fetch memAddr", fetchQ[fetchIdx], memAddr);
            end
            fetchIdx++;
        end else if (memRead) begin
            assert (loadIdx < loadAddrQ.size()) else failure("unexpected data read");
            if (loadIdx < loadAddrQ.size()) begin
                assert (memAddr == loadAddrQ[loadIdx])
                    else mismatch("load memAddr", loadAddrQ[loadIdx], memAddr);
            end
            loadIdx++;
        end
        if (memWrite) begin
            assert (storeIdx < storeAddrQ.size()) else failure("unexpected memory write");
            if (storeIdx < storeAddrQ.size()) begin
                assert (memAddr == storeAddrQ[storeIdx])
                    else mismatch("store memAddr", storeAddrQ[storeIdx], memAddr);
                assert (memWData == storeDataQ[storeIdx])
                    else mismatch("memWData", storeDataQ[storeIdx], memWData);
            end
            storeIdx++;
        end
        phase = (phase == 4) ? 0 : phase + 1;
    endtask

    // Outputs sampled mid-cycle where ready shows whether the next edge counts
    always @(negedge iClk) begin
        if (nRst) begin
            // Nothing moves across a cycle with ready low
            if (sampled && !prevRdy) begin
                assert (memAddr == prevAddr) else mismatch("frozen memAddr", prevAddr, memAddr);
                assert (memRead == prevRead) else mismatch("frozen memRead", prevRead, memRead);
                assert (memWrite == prevWrite)
                    else mismatch("frozen memWrite", prevWrite, memWrite);
            end
            if (halted) begin
                if (!haltSeen) begin
                    assert (fetchIdx == instrCount)
                        else mismatch("instructions before halt", instrCount, fetchIdx);
                    assert (storeIdx == storeAddrQ.size()) else failure("stores missing at halt");
                    assert (loadIdx == loadAddrQ.size()) else failure("loads missing at halt");
                end
                haltSeen = 1'b1;
                assert (!memRead && !memWrite) else failure("memory strobe active after halt");
            end else if (iRdy) begin
                checkStep();
            end
            prevRdy = iRdy;
            prevAddr = memAddr;
            prevRead = memRead;
            prevWrite = memWrite;
            sampled = 1'b1;
        end
    end

    // Watchdog allows four times the nominal five clocks per instruction
    initial begin
        wait (modelReady);
        #(instrCount * 5 * 20 * 4);
        failure("timeout, core never halted");
        finishRun();
    end

    initial begin
        nRst = 1'b0;
        buildProgram();
        runModel();
        modelReady = 1'b1;
        $display("Program of %0d words, %0d instructions in the model trace",
                 prog.size(), instrCount);
        @(posedge iClk);
        foreach (prog[i]) begin
            u_tbMemory.mem[i] <= prog[i];
        end
        repeat (3) @(posedge iClk);
        #2;
        nRst = 1'b1;
        // Reset state before any accepted step
        @(negedge iClk);
        assert (memRead) else failure("memory read low after reset");
        assert (!memWrite && !halted) else failure("write or halt high after reset");
        assert (memAddr == resetPc) else mismatch("reset memAddr", resetPc, memAddr);
        wait (haltSeen);
        // A few cycles with the core stopped
        repeat (8) @(posedge iClk);
        finishRun();
    end

endmodule

//--- miniCpu.f
hdl/cpuPkg.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/alu.sv
hdl/cpuControl.sv
hdl/dataPath.sv
hdl/miniCpu.sv
testbench/tbMemory.sv
testbench/miniCpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the miniCpu testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module miniCpuTb -f miniCpu.f -o miniCpuSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/miniCpuSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Verification passed" sim.log; then
    exit 0
fi
exit 1
